// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath and register bank dimensions
//////////////////////////////////////////////////

// Width of a data word and of an instruction
`define XLEN 32

// Number of architectural registers
`define REG_COUNT 32

//////////////////////////////////////////////////
// Register contents loaded on reset
//////////////////////////////////////////////////

// Registers 0 to 7
`define REG_PRESET_0 4
`define REG_PRESET_1 2
`define REG_PRESET_2 2
`define REG_PRESET_3 4
`define REG_PRESET_4 7
`define REG_PRESET_5 1
`define REG_PRESET_6 1
`define REG_PRESET_7 2
// Higher registers come up as zero

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

	// Register index as carried in an instruction
	typedef logic [4:0] reg_idx_t;

	// Primary opcodes, MIPS encoding
	typedef enum logic [5:0]
	{
		OPC_RTYPE = 6'h00,
		OPC_ADDI  = 6'h08,
		OPC_SLTI  = 6'h0a,
		OPC_ANDI  = 6'h0c,
		OPC_ORI   = 6'h0d
	} opcode_t;

	// Funct field of R-type words
	typedef enum logic [5:0]
	{
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_XOR = 6'h26,
		FN_SLT = 6'h2a
	} funct_t;

	typedef struct packed
	{
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fmt_t;

	typedef struct packed
	{
		opcode_t     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_fmt_t;

	// One instruction word, viewed as either format
	typedef union packed
	{
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

// ==== design/alu_pkg.sv ====
package alu_pkg;

	//////////////////////////////////////////////////
	// ALU control
	//////////////////////////////////////////////////

	// Operations the ALU can perform
	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	// Source of the second operand
	typedef enum logic
	{
		OPB_REG,
		OPB_IMM
	} opb_sel_t;

endpackage

// ==== design/register_file.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module register_file
	import isa_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  reg_idx_t         ra1,
	input  reg_idx_t         ra2,
	input  reg_idx_t         wa,
	input  logic [`XLEN-1:0] wd,
	input  logic             we,
	input  reg_idx_t         dbg_addr,
	output logic [`XLEN-1:0] rd1,
	output logic [`XLEN-1:0] rd2,
	output logic [`XLEN-1:0] dbg_data
);

	// Register 0 is writable like any other
	logic [`XLEN-1:0] bank [`REG_COUNT];

	// Reset value of one register
	function automatic logic [`XLEN-1:0] preset_value(input int unsigned idx);
		logic [`XLEN-1:0] val;
		case (idx)
			0: val = `REG_PRESET_0;
			1: val = `REG_PRESET_1;
			2: val = `REG_PRESET_2;
			3: val = `REG_PRESET_3;
			4: val = `REG_PRESET_4;
			5: val = `REG_PRESET_5;
			6: val = `REG_PRESET_6;
			7: val = `REG_PRESET_7;
			default: val = '0;
		endcase
		return val;
	endfunction

	//////////////////////////////////////////////////
	// Write port and preset load
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				bank[i] <= preset_value(i);
			end
		end
		else if (we)
		begin
			bank[wa] <= wd;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Operand reads
	assign rd1 = bank[ra1];
	assign rd2 = bank[ra2];

	// Debug view, unaffected by the handshake
	assign dbg_data = bank[dbg_addr];

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder
	import isa_pkg::*, alu_pkg::*;
(
	input  instr_u      instr,
	output alu_op_t     alu_op,
	output opb_sel_t    opb_sel,
	output reg_idx_t    dest,
	output logic [15:0] imm,
	output logic        imm_zext,
	output logic        illegal
);

	r_fmt_t r_word;
	i_fmt_t i_word;

	// Both views of the same word
	assign r_word = instr.r;
	assign i_word = instr.i;

	// Immediate field; ignored by R-type
	assign imm = i_word.imm;

	always_comb
	begin
		// I-type defaults with sign extension
		alu_op   = ALU_ADD;
		opb_sel  = OPB_IMM;
		dest     = i_word.rt;
		imm_zext = 1'b0;
		illegal  = 1'b0;

		case (i_word.opcode)
			OPC_RTYPE:
			begin
				// Register operands, result to rd
				opb_sel = OPB_REG;
				dest    = r_word.rd;
				case (r_word.funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_SLT: alu_op = ALU_SLT;
					default: illegal = 1'b1;
				endcase
			end
			OPC_ADDI:
			begin
				alu_op = ALU_ADD;
			end
			OPC_SLTI:
			begin
				alu_op = ALU_SLT;
			end
			// Logical immediates are zero extended
			OPC_ANDI:
			begin
				alu_op   = ALU_AND;
				imm_zext = 1'b1;
			end
			OPC_ORI:
			begin
				alu_op   = ALU_OR;
				imm_zext = 1'b1;
			end
			default:
			begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module alu_unit
	import alu_pkg::*;
(
	input  logic [`XLEN-1:0] opa,
	input  logic [`XLEN-1:0] opb_reg,
	input  logic [15:0]      imm,
	input  logic             imm_zext,
	input  opb_sel_t         opb_sel,
	input  alu_op_t          alu_op,
	output logic [`XLEN-1:0] y
);

	logic [`XLEN-1:0] imm_ext;
	logic [`XLEN-1:0] opb;
	logic             lt;

	//////////////////////////////////////////////////
	// Second operand
	//////////////////////////////////////////////////
	always_comb
	begin
		if (imm_zext)
		begin
			imm_ext = {{(`XLEN-16){1'b0}}, imm};
		end
		else
		begin
			imm_ext = {{(`XLEN-16){imm[15]}}, imm};
		end
	end

	assign opb = (opb_sel == OPB_IMM) ? imm_ext : opb_reg;

	// Signed compare for SLT and SLTI
	assign lt = $signed(opa) < $signed(opb);

	//////////////////////////////////////////////////
	// Operation
	//////////////////////////////////////////////////
	always_comb
	begin
		case (alu_op)
			// Add and subtract wrap modulo 2^XLEN
			ALU_ADD: y = opa + opb;
			ALU_SUB: y = opa - opb;
			ALU_AND: y = opa & opb;
			ALU_OR:  y = opa | opb;
			ALU_XOR: y = opa ^ opb;
			ALU_SLT: y = {{(`XLEN-1){1'b0}}, lt};
			default: y = '0;
		endcase
	end

endmodule

// ==== design/exec_core.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module exec_core
	import isa_pkg::*, alu_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [`XLEN-1:0] instr,
	input  logic             instr_req,
	input  reg_idx_t         dbg_addr,
	output logic             instr_ack,
	output logic [`XLEN-1:0] result,
	output logic             illegal,
	output logic [`XLEN-1:0] dbg_data
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_EXEC,
		ST_RELEASE
	} state_t;

	state_t state;
	instr_u instr_q;
	logic   accept;

	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;
	logic [`XLEN-1:0] alu_y;
	alu_op_t          dec_alu_op;
	opb_sel_t         dec_opb_sel;
	reg_idx_t         dec_dest;
	logic [15:0]      dec_imm;
	logic             dec_imm_zext;
	logic             dec_illegal;
	logic             reg_we;

	// New request only once the previous ack has dropped
	assign accept = (state == ST_IDLE) && instr_req && !instr_ack;

	// Commit only legal instructions
	assign reg_we = (state == ST_EXEC) && !dec_illegal;

	//////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state     <= ST_IDLE;
			instr_ack <= 1'b0;
			result    <= '0;
			illegal   <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					instr_ack <= 1'b0;
					if (accept)
					begin
						state <= ST_EXEC;
					end
				end
				ST_EXEC:
				begin
					// Register write lands on this same edge
					instr_ack <= 1'b1;
					result    <= alu_y;
					illegal   <= dec_illegal;
					state     <= ST_RELEASE;
				end
				ST_RELEASE:
				begin
					// Hold outputs until the host lets go
					if (!instr_req)
					begin
						state <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Instruction latch
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			instr_q <= instr;
		end
	end

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////
	register_file regs_i (
		.clk      (clk),
		.rst      (rst),
		.ra1      (instr_q.r.rs),
		.ra2      (instr_q.r.rt),
		.wa       (dec_dest),
		.wd       (alu_y),
		.we       (reg_we),
		.dbg_addr (dbg_addr),
		.rd1      (rd1),
		.rd2      (rd2),
		.dbg_data (dbg_data)
	);

	instr_decoder dec_i (
		.instr    (instr_q),
		.alu_op   (dec_alu_op),
		.opb_sel  (dec_opb_sel),
		.dest     (dec_dest),
		.imm      (dec_imm),
		.imm_zext (dec_imm_zext),
		.illegal  (dec_illegal)
	);

	alu_unit alu_i (
		.opa      (rd1),
		.opb_reg  (rd2),
		.imm      (dec_imm),
		.imm_zext (dec_imm_zext),
		.opb_sel  (dec_opb_sel),
		.alu_op   (dec_alu_op),
		.y        (alu_y)
	);

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen
#(
	parameter real HALF_PERIOD = 4.0
)
(
	output logic clk
);

	// 8 ns period, starts low
	initial
	begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== bench/exec_core_assert.sv ====
`timescale 1ns/10ps

module exec_core_assert
(
	input logic clk,
	input logic rst,
	input logic instr_req,
	input logic instr_ack,
	input logic reg_we,
	input logic illegal
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	// Ack only answers a request seen on the previous edge
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(instr_ack) |-> $past(instr_req))
	else
	begin
		fail_count = fail_count + 1;
		$error("instr_ack rose while instr_req was low");
	end

	// A register write is always answered with a legal acknowledge
	no_illegal_write: assert property (@(posedge clk) disable iff (rst)
		reg_we |=> (instr_ack && !illegal))
	else
	begin
		fail_count = fail_count + 1;
		$error("register write enabled for an illegal instruction");
	end

	// Ack is held until the host releases its request
	ack_held: assert property (@(posedge clk) disable iff (rst)
		(instr_ack && instr_req) |=> instr_ack)
	else
	begin
		fail_count = fail_count + 1;
		$error("instr_ack dropped before instr_req fell");
	end

endmodule

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module exec_core_tb;

	localparam int MAX_LINES      = 64;
	localparam int TIMEOUT_CYCLES = 100;
	localparam int RANDOM_READS   = 64;
	localparam int RESET_CYCLES   = 10;

	logic             clk;
	logic             rst;
	logic [`XLEN-1:0] instr;
	logic             instr_req;
	logic [4:0]       dbg_addr;
	logic             instr_ack;
	logic [`XLEN-1:0] result;
	logic             illegal;
	logic [`XLEN-1:0] dbg_data;

	// Three words per line as instruction, result and illegal flag
	logic [`XLEN-1:0] vectors [3*MAX_LINES];
	// Expected register contents
	logic [`XLEN-1:0] shadow [`REG_COUNT];
	logic [31:0]      lcg_state;
	int               line_count;

	tb_clock_gen clk_gen_i (.clk(clk));

	exec_core dut_i (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.instr_req (instr_req),
		.dbg_addr  (dbg_addr),
		.instr_ack (instr_ack),
		.result    (result),
		.illegal   (illegal),
		.dbg_data  (dbg_data)
	);

	bind exec_core exec_core_assert assert_i (
		.clk       (clk),
		.rst       (rst),
		.instr_req (instr_req),
		.instr_ack (instr_ack),
		.reg_we    (reg_we),
		.illegal   (illegal)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			abort_run($sformatf("error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// Poll instr_ack on falling edges until it reaches the level
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (instr_ack !== level)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				abort_run($sformatf("timeout waiting for instr_ack to become %0d", level));
		end
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [`XLEN-1:0] data);
		@(posedge clk);
		#1;
		dbg_addr = addr;
		@(negedge clk);
		data = dbg_data;
	endtask

	task automatic check_bank();
		logic [`XLEN-1:0] data;
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			read_reg(5'(i), data);
			check_value($sformatf("reg[%0d]", i), data, shadow[i]);
		end
	endtask

	task automatic load_presets();
		for (int i = 0; i < `REG_COUNT; i++)
			shadow[i] = '0;
		shadow[0] = `REG_PRESET_0;
		shadow[1] = `REG_PRESET_1;
		shadow[2] = `REG_PRESET_2;
		shadow[3] = `REG_PRESET_3;
		shadow[4] = `REG_PRESET_4;
		shadow[5] = `REG_PRESET_5;
		shadow[6] = `REG_PRESET_6;
		shadow[7] = `REG_PRESET_7;
	endtask

	//////////////////////////////////////////////////
	// One full four-phase transfer
	//////////////////////////////////////////////////
	task automatic run_line(input int idx);
		logic [`XLEN-1:0] word;
		logic [`XLEN-1:0] exp_result;
		logic [`XLEN-1:0] exp_illegal;
		logic [31:0]      rnd;
		logic [2:0]       hold;
		logic [4:0]       dest;
		word        = vectors[3*idx];
		exp_result  = vectors[3*idx+1];
		exp_illegal = vectors[3*idx+2];
		rnd  = lcg_next();
		hold = rnd[26:24];

		wait_ack(1'b0);
		@(posedge clk);
		#1;
		instr     = word;
		instr_req = 1'b1;
		wait_ack(1'b1);
		if (exp_illegal == 32'd0)
			check_value("result", result, exp_result);
		check_value("illegal", {31'd0, illegal}, exp_illegal);

		// Host keeps the request up for a few more cycles
		repeat (hold)
		begin
			@(negedge clk);
			check_value("instr_ack", {31'd0, instr_ack}, 32'd1);
			check_value("illegal", {31'd0, illegal}, exp_illegal);
			if (exp_illegal == 32'd0)
				check_value("result", result, exp_result);
		end

		@(posedge clk);
		#1;
		instr_req = 1'b0;
		instr     = lcg_next();
		wait_ack(1'b0);

		// R-type writes rd, I-type writes rt
		if (exp_illegal == 32'd0)
		begin
			dest = (word[31:26] == 6'h00) ? word[15:11] : word[20:16];
			shadow[dest] = exp_result;
		end
		check_bank();
	endtask

	// Failed bound assertions end the run
	always @(posedge clk)
	begin
		if (dut_i.assert_i.fail_count != 0)
			abort_run("a concurrent assertion on the DUT failed");
	end

	initial
	begin
		logic [`XLEN-1:0] data;
		logic [31:0]      rnd;
		logic [4:0]       addr;

		rst       = 1'b1;
		instr     = '0;
		instr_req = 1'b0;
		dbg_addr  = '0;
		lcg_state = 32'h99797077;

		for (int a = 0; a < 3*MAX_LINES; a++)
			vectors[a] = {~16'(a), 16'(a)};
		$readmemh("bench/exec_core_testdata.txt", vectors);
		line_count = 0;
		while (line_count < MAX_LINES && vectors[3*line_count+2] <= 32'd1)
			line_count++;
		if (line_count == 0)
			abort_run("no test lines were read from bench/exec_core_testdata.txt");
		load_presets();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_value("instr_ack", {31'd0, instr_ack}, 32'd0);
		check_value("illegal", {31'd0, illegal}, 32'd0);
		check_value("result", result, 32'd0);
		check_bank();

		for (int n = 0; n < line_count; n++)
			run_line(n);

		for (int n = 0; n < RANDOM_READS; n++)
		begin
			rnd  = lcg_next();
			addr = rnd[31:27];
			read_reg(addr, data);
			check_value($sformatf("dbg_data[%0d]", addr), data, shadow[addr]);
		end

		if (dut_i.assert_i.fail_count == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			abort_run("a concurrent assertion on the DUT failed");
		end
	end

endmodule

// ==== bench/exec_core_testdata.txt ====
// Columns: instruction word, expected result, expected illegal flag (all hex)
// The result column is not compared on illegal lines
// R-type ADD, SUB, AND, OR, XOR, SLT
00834020 0000000b 0
00A44822 fffffffa 0
00835024 00000004 0
00675825 00000006 0
00816026 00000005 0
0125682A 00000001 0
00A9702A 00000000 0
// I-type ADDI, ANDI, ORI, SLTI
208F7FFF 00008006 0
2010FFF0 fffffff4 0
3131FF0F 0000ff0a 0
34728000 00008004 0
2933FFF9 00000000 0
2934FFFB 00000001 0
// Illegal opcodes and functs
FC221800 00000000 1
00221821 00000000 1
00221800 00000000 1
8C430004 00000000 1
08000010 00000000 1
// Wrapping arithmetic and writes to register 0
0124A820 00000001 0
01CDB022 ffffffff 0
20000005 00000009 0
0000B820 00000012 0
// Mixed operations on earlier results
02D1C026 ffff00f5 0
0310C824 ffff00f4 0
01F2D025 00008006 0
02C9D82A 00000000 0
0136E02A 00000001 0
0038E82A 00000000 0
32DE8001 00008001 0
361F00FF ffffffff 0
2801000A 00000001 0
2A027FFF 00000001 0
23E38000 ffff7fff 0
00842020 0000000e 0
007F2822 ffff8000 0
00223027 00000000 1
30A6FFFF 00008000 0

// ==== files.f ====
+incdir+include
design/isa_pkg.sv
design/alu_pkg.sv
design/register_file.sv
design/instr_decoder.sv
design/alu_unit.sv
design/exec_core.sv
bench/tb_clock_gen.sv
bench/exec_core_assert.sv
bench/exec_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the execution core testbench

VERILATOR  ?= verilator
TOP        ?= exec_core_tb
RTL_TOP    ?= exec_core
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/10ps
RTL_SRCS   ?= design/isa_pkg.sv design/alu_pkg.sv design/register_file.sv \
	design/instr_decoder.sv design/alu_unit.sv design/exec_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+include $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
